// ==== sources.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_decoder.sv
rtl/rv_control_fsm.sv
rtl/rv_pc_counter.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_core.sv
dv/tb_rv_memory.sv
dv/tb_rv_core.sv

// ==== dv/tb_rv_core.sv ====
// Runs one fixed program of at most 256 words; expected values follow RV32I rules on LCG operands
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core
    import rv_core_pkg::*;
();

    localparam int          clk_period = 40;
    localparam logic [6:0]  op_load    = 7'b0000011;
    localparam logic [6:0]  op_imm     = 7'b0010011;
    localparam logic [6:0]  op_store   = 7'b0100011;
    localparam logic [6:0]  op_reg     = 7'b0110011;
    localparam logic [6:0]  op_branch  = 7'b1100011;
    localparam logic [6:0]  op_jalr    = 7'b1100111;
    localparam logic [6:0]  op_jal     = 7'b1101111;
    localparam logic [31:0] ecall      = 32'h0000_0073;

    logic        clk;
    logic        arst_n;
    logic        imem_rd;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        dmem_rd;
    logic        dmem_wr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        halt;

    logic [31:0] prog [256];            // Own copy of the program
    logic [31:0] next_fetch [256];      // Successor of each word address
    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];
    string       store_name_q [$];
    logic [31:0] seed = 32'h6ce5;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imx;                   // Sign-extended immediate
    logic [11:0] imm12;
    logic [4:0]  sh;
    logic [31:0] build_pc = `RV_RESET_PC;
    logic [31:0] store_off = 32'h40;
    logic [31:0] last_fetch;
    logic [31:0] ecall_addr;
    int          n_inst = 0;
    int          since_fetch = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;
    bit          fetch_seen = 1'b0;
    bit          halt_seen = 1'b0;
    bit          built = 1'b0;

    rv_core uut (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .o_imem_rd    (imem_rd),
        .o_imem_addr  (imem_addr),
        .i_imem_rdata (imem_rdata),
        .o_dmem_rd    (dmem_rd),
        .o_dmem_wr    (dmem_wr),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .o_halt       (halt)
    );

    tb_rv_memory u_memory (
        .i_clk        (clk),
        .i_imem_rd    (imem_rd),
        .i_imem_addr  (imem_addr),
        .o_imem_rdata (imem_rdata),
        .i_dmem_rd    (dmem_rd),
        .i_dmem_wr    (dmem_wr),
        .i_dmem_addr  (dmem_addr),
        .i_dmem_wdata (dmem_wdata),
        .o_dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // x3 = x1 op x2
    function automatic logic [31:0] reg_reg_op(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // x3 = x1 op imm
    function automatic logic [31:0] reg_imm_op(input logic [11:0] imm, input logic [2:0] f3);
        return i_type(imm, 5'd1, f3, 5'd3, op_imm);
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic bit branch_rule(input logic [2:0] f3, input logic [31:0] x, y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic place(input logic [31:0] inst);
        prog[build_pc[9:2]]       = inst;
        u_memory.imem[build_pc[9:2]] = inst;
        next_fetch[build_pc[9:2]] = build_pc + 32'd4;   // Sequential unless overridden
        build_pc = build_pc + 32'd4;
        n_inst++;
    endtask

    // SW rs, store_off(x0) and the value it must write
    task automatic expect_store(input string name, input logic [4:0] rs, input logic [31:0] data);
        place(s_type(store_off[11:0], rs, 5'd0));
        store_addr_q.push_back(store_off);
        store_data_q.push_back(data);
        store_name_q.push_back(name);
        store_off = store_off + 32'd4;
    endtask

    task automatic arith_test(input string name, input logic [31:0] inst, input logic [31:0] data);
        place(inst);
        expect_store(name, 5'd3, data);
    endtask

    // Both paths set x5 to a marker, then join at the store
    task automatic branch_test(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [31:0] x, input logic [31:0] y,
                               input logic [11:0] marker);
        logic [31:0] br_pc;
        bit          taken;
        br_pc = build_pc;
        taken = branch_rule(f3, x, y);
        place(b_type(13'd12, rs2, rs1, f3));
        next_fetch[br_pc[9:2]] = taken ? br_pc + 32'd12 : br_pc + 32'd4;
        place(i_type(marker, 5'd0, 3'b000, 5'd5, op_imm));
        place(j_type(21'd8, 5'd0));                             // Link goes to x0
        next_fetch[br_pc[9:2] + 8'd2] = br_pc + 32'd16;
        place(i_type(marker + 12'd1, 5'd0, 3'b000, 5'd5, op_imm));
        expect_store(name, 5'd5, {20'd0, taken ? marker + 12'd1 : marker});
    endtask

    task automatic build_program();
        logic [31:0] jump_pc;
        for (int i = 0; i < 256; i++) begin
            prog[i]          = {i[24:0], 7'b1110011};           // SYSTEM, halts if reached
            u_memory.imem[i] = prog[i];
            u_memory.dmem[i] = {~i[15:0], i[15:0]};
        end
        seed = lcg_next(seed);
        a = seed | 32'h8000_0000;                               // Negative
        seed = lcg_next(seed);
        b = seed & 32'h7fff_ffff;                               // Positive
        seed = lcg_next(seed);
        imm12 = seed[11:0];
        imx = {{20{imm12[11]}}, imm12};
        sh = seed[16:12];
        u_memory.dmem[0] = a;
        u_memory.dmem[1] = b;
        place(i_type(12'd0, 5'd0, 3'b010, 5'd1, op_load));
        place(i_type(12'd4, 5'd0, 3'b010, 5'd2, op_load));
        expect_store("lw", 5'd1, a);
        arith_test("add", reg_reg_op(7'h00, 3'b000), a + b);
        arith_test("sub", reg_reg_op(7'h20, 3'b000), a - b);
        arith_test("sll", reg_reg_op(7'h00, 3'b001), a << b[4:0]);
        arith_test("slt", reg_reg_op(7'h00, 3'b010), {31'd0, $signed(a) < $signed(b)});
        arith_test("sltu", reg_reg_op(7'h00, 3'b011), {31'd0, a < b});
        arith_test("xor", reg_reg_op(7'h00, 3'b100), a ^ b);
        arith_test("srl", reg_reg_op(7'h00, 3'b101), a >> b[4:0]);
        arith_test("sra", reg_reg_op(7'h20, 3'b101), $signed(a) >>> b[4:0]);
        arith_test("or", reg_reg_op(7'h00, 3'b110), a | b);
        arith_test("and", reg_reg_op(7'h00, 3'b111), a & b);
        arith_test("addi", reg_imm_op(imm12, 3'b000), a + imx);
        arith_test("slti", reg_imm_op(imm12, 3'b010), {31'd0, $signed(a) < $signed(imx)});
        arith_test("sltiu", reg_imm_op(imm12, 3'b011), {31'd0, a < imx});
        arith_test("xori", reg_imm_op(imm12, 3'b100), a ^ imx);
        arith_test("ori", reg_imm_op(imm12, 3'b110), a | imx);
        arith_test("andi", reg_imm_op(imm12, 3'b111), a & imx);
        arith_test("slli", reg_imm_op({7'h00, sh}, 3'b001), a << sh);
        arith_test("srli", reg_imm_op({7'h00, sh}, 3'b101), a >> sh);
        arith_test("srai", reg_imm_op({7'h20, sh}, 3'b101), $signed(a) >>> sh);
        branch_test("beq_taken", 3'b000, 5'd1, 5'd1, a, a, 12'h100);
        branch_test("beq_not", 3'b000, 5'd1, 5'd2, a, b, 12'h102);
        branch_test("bne_taken", 3'b001, 5'd1, 5'd2, a, b, 12'h104);
        branch_test("bne_not", 3'b001, 5'd1, 5'd1, a, a, 12'h106);
        branch_test("blt_taken", 3'b100, 5'd1, 5'd2, a, b, 12'h108);
        branch_test("blt_not", 3'b100, 5'd2, 5'd1, b, a, 12'h10a);
        branch_test("bge_taken", 3'b101, 5'd2, 5'd1, b, a, 12'h10c);
        branch_test("bge_not", 3'b101, 5'd1, 5'd2, a, b, 12'h10e);
        branch_test("bltu_taken", 3'b110, 5'd2, 5'd1, b, a, 12'h110);
        branch_test("bltu_not", 3'b110, 5'd1, 5'd2, a, b, 12'h112);
        branch_test("bgeu_taken", 3'b111, 5'd1, 5'd2, a, b, 12'h114);
        branch_test("bgeu_not", 3'b111, 5'd2, 5'd1, b, a, 12'h116);
        jump_pc = build_pc;                                     // JAL x6 over a trap
        place(j_type(21'd8, 5'd6));
        next_fetch[jump_pc[9:2]] = jump_pc + 32'd8;
        place(ecall);
        expect_store("jal_link", 5'd6, jump_pc + 32'd4);
        place(i_type(build_pc[11:0] + 12'd12, 5'd0, 3'b000, 5'd7, op_imm));
        jump_pc = build_pc;                                     // JALR x8, 1(x7), odd target
        place(i_type(12'd1, 5'd7, 3'b000, 5'd8, op_jalr));
        next_fetch[jump_pc[9:2]] = jump_pc + 32'd8;
        place(ecall);
        expect_store("jalr_link", 5'd8, jump_pc + 32'd4);
        place(i_type(12'h055, 5'd0, 3'b000, 5'd0, op_imm));     // Write to x0
        expect_store("x0_write", 5'd0, 32'd0);
        ecall_addr = build_pc;
        place(ecall);
    endtask

    task automatic check_quiet(input string when);
        assert (!imem_rd && !dmem_rd && !dmem_wr && !halt) else begin
            $display("A strobe or o_halt is high %s at %0t", when, $time);
            protocol_errors++;
        end
    endtask

    task automatic check_store();
        string       name;
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        assert (store_addr_q.size() > 0) else begin
            $display("Unexpected store to %h at %0t", dmem_addr, $time);
            protocol_errors++;
        end
        if (store_addr_q.size() > 0) begin
            name     = store_name_q.pop_front();
            exp_addr = store_addr_q.pop_front();
            exp_data = store_data_q.pop_front();
            assert (dmem_addr == exp_addr) else begin
                $display("FAILED %s address: expected %h, actual %h", name, exp_addr, dmem_addr);
                value_errors++;
            end
            assert (dmem_wdata == exp_data) else begin
                $display("FAILED %s data: expected %h, actual %h", name, exp_data, dmem_wdata);
                value_errors++;
            end
        end
    endtask

    task automatic check_fetch();
        int gap;
        if (fetch_seen) begin
            gap = (prog[last_fetch[9:2]][6:0] == op_load) ? 5 : 4;   // Loads add MEMORY
            assert (since_fetch == gap) else begin
                $display("Fetch of %h came %0d cycles after the previous one instead of %0d",
                         imem_addr, since_fetch, gap);
                protocol_errors++;
            end
            assert (imem_addr == next_fetch[last_fetch[9:2]]) else begin
                $display("FAILED fetch_after_%h: expected %h, actual %h", last_fetch,
                         next_fetch[last_fetch[9:2]], imem_addr);
                value_errors++;
            end
        end else begin
            assert (imem_addr == `RV_RESET_PC) else begin
                $display("FAILED reset_pc: expected %h, actual %h", `RV_RESET_PC, imem_addr);
                value_errors++;
            end
        end
        fetch_seen  = 1'b1;
        last_fetch  = imem_addr;
        since_fetch = 1;
    endtask

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            check_quiet("during reset");
        end
        assert (!(dmem_rd && dmem_wr)) else begin
            $display("Data read and write strobes are both high at %0t", $time);
            protocol_errors++;
        end
        if (halt_seen) begin
            assert (halt && uut.u_control_fsm.state_q == ST_HALT &&
                    !imem_rd && !dmem_rd && !dmem_wr) else begin
                $display("Core left the halted state or strobed after halt at %0t", $time);
                protocol_errors++;
            end
        end
        if (halt) begin
            halt_seen = 1'b1;
        end
        if (dmem_wr) begin
            check_store();
        end
        if (imem_rd) begin
            check_fetch();
        end else begin
            since_fetch++;
        end
    end

    initial begin
        wait (built);
        #(2 * n_inst * 5 * clk_period);
        $display("Watchdog timeout, the core did not halt within the cycle budget");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        build_program();
        built = 1'b1;
        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;
        @(negedge clk);
        check_quiet("on the first cycle after reset");
        wait (halt);
        repeat (8) @(negedge clk);                              // Watch for late strobes
        assert (store_addr_q.size() == 0) else begin
            $display("%0d expected stores never happened", store_addr_q.size());
            protocol_errors++;
        end
        assert (last_fetch == ecall_addr) else begin
            $display("FAILED halt_addr: expected %h, actual %h", ecall_addr, last_fetch);
            value_errors++;
        end
        $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_rv_memory.sv ====
// Behavioral 1 KiB instruction and 1 KiB data memories, word access only; upper address bits alias
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module tb_rv_memory (
    input  wire logic                i_clk,
    input  wire logic                i_imem_rd,
    input  wire logic [`RV_XLEN-1:0] i_imem_addr,
    output logic      [`RV_XLEN-1:0] o_imem_rdata,
    input  wire logic                i_dmem_rd,
    input  wire logic                i_dmem_wr,
    input  wire logic [`RV_XLEN-1:0] i_dmem_addr,
    input  wire logic [`RV_XLEN-1:0] i_dmem_wdata,
    output logic      [`RV_XLEN-1:0] o_dmem_rdata
);

    localparam int drive_delay = 2;     // ns after the rising edge

    logic [`RV_XLEN-1:0] imem [256];    // Loaded by the testbench
    logic [`RV_XLEN-1:0] dmem [256];

    initial begin
        o_imem_rdata = '0;
        o_dmem_rdata = '0;
    end

    // Read data shows up one cycle after the strobe and holds until the next strobe
    always @(posedge i_clk) begin
        if (i_imem_rd) begin
            o_imem_rdata <= #drive_delay imem[i_imem_addr[9:2]];
        end
        if (i_dmem_rd) begin
            o_dmem_rdata <= #drive_delay dmem[i_dmem_addr[9:2]];
        end
        if (i_dmem_wr) begin
            dmem[i_dmem_addr[9:2]] <= i_dmem_wdata;   // Lands on the strobe edge
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
// Multicycle RV32I subset with word accesses only; memories reply one cycle after a strobe and hold
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_core
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  wire logic                i_clk,
    input  wire logic                i_arst_n,
    output logic                     o_imem_rd,
    output logic      [`RV_XLEN-1:0] o_imem_addr,
    input  wire logic [`RV_XLEN-1:0] i_imem_rdata,
    output logic                     o_dmem_rd,
    output logic                     o_dmem_wr,
    output logic      [`RV_XLEN-1:0] o_dmem_addr,
    output logic      [`RV_XLEN-1:0] o_dmem_wdata,
    input  wire logic [`RV_XLEN-1:0] i_dmem_rdata,
    output logic                     o_halt
);

    rv_opcode_e          op;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [4:0]          sh;
    logic [2:0]          funct3;
    logic                funct7_b5;
    logic [`RV_XLEN-1:0] imm;
    logic                pc_inc;
    logic                pc_branch;
    logic                pc_jump;
    logic                rf_we;
    rv_alu_op_e          alu_op;
    rv_b_sel_e           b_sel;
    rv_wb_sel_e          wb_sel;
    logic                alu_zero;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] wb_data;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;

    rv_decoder u_decoder (
        .i_inst      (i_imem_rdata),   // Held by the memory so no local copy
        .o_op        (op),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_rd        (rd),
        .o_sh        (sh),
        .o_funct3    (funct3),
        .o_funct7_b5 (funct7_b5),
        .o_imm       (imm)
    );

    rv_control_fsm u_control_fsm (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_op        (op),
        .i_funct3    (funct3),
        .i_funct7_b5 (funct7_b5),
        .i_alu_zero  (alu_zero),
        .o_imem_rd   (o_imem_rd),
        .o_dmem_rd   (o_dmem_rd),
        .o_dmem_wr   (o_dmem_wr),
        .o_pc_inc    (pc_inc),
        .o_pc_branch (pc_branch),
        .o_pc_jump   (pc_jump),
        .o_rf_we     (rf_we),
        .o_alu_op    (alu_op),
        .o_b_sel     (b_sel),
        .o_wb_sel    (wb_sel),
        .o_halt      (o_halt)
    );

    rv_pc_counter u_pc_counter (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_inc         (pc_inc),
        .i_branch      (pc_branch),
        .i_jump        (pc_jump),
        .i_imm         (imm),
        .i_jump_target (alu_result),   // rs1 + imm for JALR
        .o_pc          (pc),
        .o_pc_plus4    (pc_plus4)
    );

    // Second ALU operand
    always_comb begin
        case (b_sel)
            B_IMM:   alu_b = imm;
            B_SHAMT: alu_b = {{(`RV_XLEN-5){1'b0}}, sh};
            default: alu_b = rs2_data;
        endcase
    end

    rv_alu u_alu (
        .i_op     (alu_op),
        .i_a      (rs1_data),
        .i_b      (alu_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    // Writeback source
    always_comb begin
        case (wb_sel)
            WB_LOAD: wb_data = i_dmem_rdata;
            WB_LINK: wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (rd),
        .i_we       (rf_we),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    assign o_imem_addr  = pc;
    assign o_dmem_addr  = alu_result;  // rs1 + imm for loads and stores
    assign o_dmem_wdata = rs2_data;

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
// Asynchronous reads, one write per edge; every register clears at reset and x0 is never written
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_regfile (
    input  wire logic                i_clk,
    input  wire logic                i_arst_n,
    input  wire logic [4:0]          i_rs1,
    input  wire logic [4:0]          i_rs2,
    input  wire logic [4:0]          i_rd,
    input  wire logic                i_we,
    input  wire logic [`RV_XLEN-1:0] i_wdata,
    output logic      [`RV_XLEN-1:0] o_rs1_data,
    output logic      [`RV_XLEN-1:0] o_rs2_data
);

    logic [`RV_XLEN-1:0] regs_q [`RV_REG_COUNT];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_we && (i_rd != 5'd0)) begin
            regs_q[i_rd] <= i_wdata;    // x0 keeps its reset value
        end
    end

    assign o_rs1_data = regs_q[i_rs1];
    assign o_rs2_data = regs_q[i_rs2];

endmodule

`default_nettype wire

// ==== rtl/rv_alu.sv ====
// Combinational only; shifts use the low 5 bits of operand B, no overflow flag
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_alu
    import rv_core_pkg::*;
(
    input  rv_alu_op_e                i_op,
    input  wire logic [`RV_XLEN-1:0]  i_a,
    input  wire logic [`RV_XLEN-1:0]  i_b,
    output logic      [`RV_XLEN-1:0]  o_result,
    output logic                      o_zero     // Branch decisions
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SLT: begin
                o_result = {{(`RV_XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            end
            ALU_SLTU: begin
                o_result = {{(`RV_XLEN-1){1'b0}}, i_a < i_b};
            end
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SRA:  o_result = $signed(i_a) >>> shamt;   // Sign fill
            ALU_OR:   o_result = i_a | i_b;
            ALU_AND:  o_result = i_a & i_b;
            default:  o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// ==== rtl/rv_pc_counter.sv ====
// Strobes are mutually exclusive; no misaligned-target check, JALR bit 0 is simply cleared
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_pc_counter (
    input  wire logic                i_clk,
    input  wire logic                i_arst_n,
    input  wire logic                i_inc,          // Next sequential instruction
    input  wire logic                i_branch,       // Taken branch or JAL
    input  wire logic                i_jump,         // JALR
    input  wire logic [`RV_XLEN-1:0] i_imm,
    input  wire logic [`RV_XLEN-1:0] i_jump_target,
    output logic      [`RV_XLEN-1:0] o_pc,
    output logic      [`RV_XLEN-1:0] o_pc_plus4     // Also the link address
);

    logic [`RV_XLEN-1:0] pc_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= `RV_RESET_PC;
        end else if (i_jump) begin
            pc_q <= {i_jump_target[`RV_XLEN-1:1], 1'b0};
        end else if (i_branch) begin
            pc_q <= pc_q + i_imm;                        // PC-relative
        end else if (i_inc) begin
            pc_q <= o_pc_plus4;
        end
    end

    assign o_pc       = pc_q;
    assign o_pc_plus4 = pc_q + `RV_XLEN'd4;

endmodule

`default_nettype wire

// ==== rtl/rv_control_fsm.sv ====
// One instruction in flight and no back-pressure; SYSTEM and unknown opcodes halt
`timescale 1ns/1ns
`default_nettype none

module rv_control_fsm
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_arst_n,
    input  rv_opcode_e      i_op,
    input  wire logic [2:0] i_funct3,
    input  wire logic       i_funct7_b5,
    input  wire logic       i_alu_zero,
    output logic            o_imem_rd,
    output logic            o_dmem_rd,
    output logic            o_dmem_wr,
    output logic            o_pc_inc,
    output logic            o_pc_branch,
    output logic            o_pc_jump,
    output logic            o_rf_we,
    output rv_alu_op_e      o_alu_op,
    output rv_b_sel_e       o_b_sel,
    output rv_wb_sel_e      o_wb_sel,
    output logic            o_halt
);

    rv_state_e state_q;
    rv_state_e state_next;
    logic      run_q;        // Low until the first edge after reset release
    logic      legal_op;
    logic      br_taken;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ST_FETCH;
            run_q   <= 1'b0;
        end else begin
            state_q <= state_next;
            run_q   <= 1'b1;
        end
    end

    // Supported opcodes keep running and the rest stop the core
    always_comb begin
        case (i_op)
            OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE,
            OPC_BRANCH, OPC_JAL, OPC_JALR: legal_op = 1'b1;
            default:                       legal_op = 1'b0;
        endcase
    end

    always_comb begin
        case (state_q)
            ST_FETCH:     state_next = run_q ? ST_DECODE : ST_FETCH;
            ST_DECODE:    state_next = legal_op ? ST_EXECUTE : ST_HALT;
            ST_EXECUTE:   state_next = (i_op == OPC_LOAD) ? ST_MEMORY : ST_WRITEBACK;
            ST_MEMORY:    state_next = ST_WRITEBACK;
            ST_WRITEBACK: state_next = ST_FETCH;
            default:      state_next = ST_HALT;
        endcase
    end

    // ALU operation and operand source follow the held instruction in every state
    always_comb begin
        o_alu_op = ALU_ADD;                     // Address and JALR target
        o_b_sel  = B_IMM;
        case (i_op)
            OPC_OP, OPC_OP_IMM: begin
                if (i_op == OPC_OP) begin
                    o_b_sel = B_REG;
                end
                case (rv_funct3_e'(i_funct3))
                    F3_ADD_SUB: o_alu_op = (i_op == OPC_OP && i_funct7_b5) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     o_alu_op = ALU_SLL;
                    F3_SLT:     o_alu_op = ALU_SLT;
                    F3_SLTU:    o_alu_op = ALU_SLTU;
                    F3_XOR:     o_alu_op = ALU_XOR;
                    F3_SRL_SRA: o_alu_op = i_funct7_b5 ? ALU_SRA : ALU_SRL;
                    F3_OR:      o_alu_op = ALU_OR;
                    default:    o_alu_op = ALU_AND;
                endcase
                if (i_op == OPC_OP_IMM && (rv_funct3_e'(i_funct3) == F3_SLL ||
                                           rv_funct3_e'(i_funct3) == F3_SRL_SRA)) begin
                    o_b_sel = B_SHAMT;
                end
            end
            OPC_BRANCH: begin
                o_b_sel = B_REG;
                case (rv_branch_e'(i_funct3))
                    BEQ, BNE:   o_alu_op = ALU_SUB;
                    BLT, BGE:   o_alu_op = ALU_SLT;
                    default:    o_alu_op = ALU_SLTU;
                endcase
            end
            default: ;
        endcase
    end

    // Zero flag means equal for SUB and "not less" for SLT and SLTU
    always_comb begin
        case (rv_branch_e'(i_funct3))
            BEQ, BGE, BGEU:  br_taken = i_alu_zero;
            BNE, BLT, BLTU:  br_taken = !i_alu_zero;
            default:         br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (i_op)
            OPC_LOAD:          o_wb_sel = WB_LOAD;
            OPC_JAL, OPC_JALR: o_wb_sel = WB_LINK;
            default:           o_wb_sel = WB_ALU;
        endcase
    end

    assign o_imem_rd = (state_q == ST_FETCH) && run_q;
    assign o_dmem_rd = (state_q == ST_EXECUTE) && (i_op == OPC_LOAD);
    assign o_dmem_wr = (state_q == ST_EXECUTE) && (i_op == OPC_STORE);
    assign o_halt    = (state_q == ST_HALT);

    // Exactly one counter strobe per instruction and only in WRITEBACK
    always_comb begin
        o_pc_inc    = 1'b0;
        o_pc_branch = 1'b0;
        o_pc_jump   = 1'b0;
        o_rf_we     = 1'b0;
        if (state_q == ST_WRITEBACK) begin
            o_rf_we = (i_op != OPC_STORE) && (i_op != OPC_BRANCH);
            if (i_op == OPC_JAL || (i_op == OPC_BRANCH && br_taken)) begin
                o_pc_branch = 1'b1;
            end else if (i_op == OPC_JALR) begin
                o_pc_jump = 1'b1;
            end else begin
                o_pc_inc = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_decoder.sv ====
// Purely combinational; relies on the instruction word staying stable for the whole instruction
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_decoder
    import rv_isa_pkg::*;
(
    input  wire logic [31:0]          i_inst,      // Instruction word held by the memory
    output rv_opcode_e                o_op,
    output logic [4:0]                o_rs1,
    output logic [4:0]                o_rs2,
    output logic [4:0]                o_rd,
    output logic [4:0]                o_sh,        // Shift amount, immediate shifts only
    output logic [2:0]                o_funct3,
    output logic                      o_funct7_b5, // SUB and SRA select
    output logic [`RV_XLEN-1:0]       o_imm
);

    assign o_op        = rv_opcode_e'(i_inst[6:0]);
    assign o_funct3    = i_inst[14:12];
    assign o_funct7_b5 = i_inst[30];

    // Register fields sit at fixed positions in every format
    assign o_rs1 = i_inst[19:15];
    assign o_rs2 = i_inst[24:20];
    assign o_rd  = i_inst[11:7];

    // Immediate by format, sign bit is always inst[31]
    always_comb begin
        case (o_op)
            OPC_OP_IMM,
            OPC_LOAD,
            OPC_JALR: begin
                o_imm = {{20{i_inst[31]}}, i_inst[31:20]};                  // I-type
            end
            OPC_STORE: begin
                o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};    // S-type
            end
            OPC_BRANCH: begin
                o_imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25],
                         i_inst[11:8], 1'b0};                               // B-type
            end
            OPC_JAL: begin
                o_imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20],
                         i_inst[30:21], 1'b0};                              // J-type
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

    // Shift distance only for SLLI, SRLI and SRAI
    always_comb begin
        o_sh = '0;
        if (o_op == OPC_OP_IMM) begin
            case (rv_funct3_e'(o_funct3))
                F3_SLL,
                F3_SRL_SRA: o_sh = i_inst[24:20];
                default:    o_sh = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core_pkg.sv ====
// Internal control encodings of the multicycle core; not tied to any instruction field
`default_nettype none

package rv_core_pkg;

    // Sequencer states, one instruction in flight
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK,
        ST_HALT
    } rv_state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } rv_alu_op_e;

    typedef enum logic [1:0] {
        B_REG,   // rs2 value
        B_IMM,   // Sign-extended immediate
        B_SHAMT  // Immediate shift distance
    } rv_b_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK  // pc + 4 for JAL and JALR
    } rv_wb_sel_e;

endpackage

`default_nettype wire

// ==== rtl/rv_isa_pkg.sv ====
// RV32I encoding types for the supported subset only; no U-type, FENCE or CSR encodings
`default_nettype none

package rv_isa_pkg;

    // Major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    // Branch conditions in funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } rv_branch_e;

    // Arithmetic functions in funct3 for OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } rv_funct3_e;

endpackage

`default_nettype wire

// ==== rtl/rv_settings.svh ====
// Fixed RV32I widths and reset fetch address shared by the core; XLEN other than 32 is unsupported
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and address width
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_REG_COUNT 32

// First fetch address after reset release
`define RV_RESET_PC 32'h0000_0000

`endif
